/* bench/main_checks.svh */
// Bus access, compare and directed test tasks for the main board testbench
// Included in the body of the testbench module

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand32();
        seed = lcg_step(seed);
        return seed;
    endfunction

    // ROM contents as low address byte XOR high address byte
    function automatic logic [7:0] rom_byte(input logic [ROM_AW-1:0] a);
        return a[7:0] ^ a[16:9];
    endfunction

    function automatic logic [7:0] exp_port(input int p);
        logic [5:0] j;
        j = (p == 1) ? cab.joy1 : cab.joy2;
        case (p)
            0:       return {3'b111, cab.start, cab.service, cab.coin};
            1, 2:    return {2'b11, j[5], j[4], j[2], j[3], j[0], j[1]};
            4:       return dip.dip_a;
            5:       return dip.dip_b;
            6:       return {4'hf, dip.dip_c};
            default: return 8'hff;
        endcase
    endfunction

    task automatic chk_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s exp %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic chk_rom_addr(input string name, input logic [ROM_AW-1:0] exp,
                                input logic [ROM_AW-1:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s exp %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic chk_vid_addr(input string name, input logic [12:0] exp,
                                input logic [12:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s exp %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic chk_bit(input string name, input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s exp %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    // One full four-phase cycle with outputs sampled on the falling edge
    task automatic bus_access(input logic [15:0] a, input logic is_rd, input logic [7:0] wd,
                              output logic [7:0] rdata);
        int n;
        @(posedge clk);
        bus <= '{addr: a, rnw: is_rd, wdata: wd};
        req <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ack && n < 64);
        if (!ack) begin
            errors++;
            $display("no ack for the access to %h", a);
        end
        rdata         = rd_data;
        last_lat      = 8'(n - 1);
        last_rom_addr = rom_addr;
        last_gfx1_cs  = gfx1_cs;
        last_gfx2_cs  = gfx2_cs;
        last_pal_cs   = pal_cs;
        if (!is_rd || a[15:14] == 2'b00) chk_byte("ack latency", 8'd2, last_lat);
        @(posedge clk);
        req <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (ack && n < 64);
        if (ack) begin
            errors++;
            $display("ack stayed high after req dropped at %h", a);
        end
        chk_byte("ack release", 8'd2, 8'(n));
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        logic [7:0] unused;
        bus_access(a, 1'b0, d, unused);
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
        bus_access(a, 1'b1, 8'h00, d);
    endtask

    task automatic test_reset_values();
        @(negedge clk);
        chk_bit("ack", 1'b0, ack);
        chk_bit("rom_cs", 1'b0, rom_cs);
        chk_bit("vid_we", 1'b0, vid_we);
        chk_bit("gfx1_cs", 1'b0, gfx1_cs);
        chk_bit("gfx2_cs", 1'b0, gfx2_cs);
        chk_bit("snd_irq", 1'b0, snd_irq);
        chk_bit("irq_n", 1'b1, irq_n);
        chk_bit("prio", 1'b0, prio);
        chk_byte("video_bank", 8'h00, video_bank);
        chk_byte("snd_latch", 8'h00, snd_latch);
    endtask

    task automatic test_rom_reads();
        logic [31:0]       r;
        logic [15:0]       a;
        logic [7:0]        d;
        logic [3:0]        bk;
        bank_fields_t      f;
        logic [ROM_AW-1:0] exp_a;
        for (int i = 0; i < 8; i++) begin     // Fixed upper 32 KB
            r = rand32();
            a = {1'b1, r[30:16]};
            bus_read(a, d);
            exp_a = ROM_AW'(a - 16'h8000);    // Offset into the fixed area
            chk_rom_addr("rom_addr", exp_a, last_rom_addr);
            chk_byte("rom rd_data", rom_byte(exp_a), d);
        end
        for (int i = 0; i < 6; i++) begin     // Banks 0 to 15 in steps of 3 with the wrap
            r = rand32();
            bk = 4'(3 * i);
            f = '0;
            f.bank_en = 1'b1;
            f.bank = bk;
            bus_write(16'h0410, f);
            a = {2'b01, r[29:16]};
            bus_read(a, d);
            // Page (bank + 4) mod 16, 8 KB each
            exp_a = ROM_AW'((int'(bk) + 4) % 16 * 32'h2000 + int'(a[12:0]));
            chk_rom_addr("rom_addr banked", exp_a, last_rom_addr);
            chk_byte("rom rd_data banked", rom_byte(exp_a), d);
        end
        bus_write(16'h0410, 8'h00);
    endtask

    task automatic test_ram();
        logic [31:0] r;
        logic [7:0]  d;
        logic [15:0] addrs [8];
        logic [7:0]  vals [8];
        for (int i = 0; i < 8; i++) begin
            r = rand32();
            addrs[i] = {4'h1, r[24:16], 3'(i)};   // Low bits keep them distinct
            vals[i] = r[31:24];
            bus_write(addrs[i], vals[i]);
        end
        for (int i = 0; i < 8; i++) begin
            bus_read(addrs[i], d);
            chk_byte("ram rd_data", vals[i], d);
        end
    endtask

    task automatic test_inputs();
        logic [31:0] r;
        logic [31:0] r2;
        logic [7:0]  d;
        logic [15:0] ff_addrs [9] = '{16'h0408, 16'h041c, 16'h0420, 16'h0800, 16'h0a00,
                                      16'h040c, 16'h0410, 16'h0414, 16'h0418};
        for (int k = 0; k < 3; k++) begin
            r = rand32();
            r2 = rand32();
            @(posedge clk);
            cab <= r[31:13];
            dip <= r2[31:11];
            for (int p = 0; p < 8; p++) begin
                bus_read(16'h0400 | 16'(p), d);
                chk_byte("port rd_data", exp_port(p), d);
            end
        end
        foreach (ff_addrs[i]) begin        // Unmapped and write-only
            bus_read(ff_addrs[i], d);
            chk_byte("ff rd_data", 8'hff, d);
        end
    endtask

    task automatic test_video();
        bank_fields_t f;
        logic [31:0]  r;
        logic [7:0]   d;
        int           w0;
        f = '0;
        f.prio = 1'b1;
        bus_write(16'h0410, f);
        chk_bit("prio", 1'b1, prio);
        bus_read(16'h2000, d);
        chk_byte("gfx1 rd_data", 8'h5a, d);
        chk_bit("gfx1_cs", 1'b1, last_gfx1_cs);
        chk_bit("gfx2_cs", 1'b0, last_gfx2_cs);
        bus_read(16'h01f0, d);               // Low video window
        chk_byte("gfx1 rd_data low", 8'h5a, d);
        f.prio = 1'b0;
        f.video_sel = 1'b1;
        bus_write(16'h0410, f);
        chk_bit("prio", 1'b0, prio);
        bus_read(16'h3abc, d);
        chk_byte("gfx2 rd_data", 8'ha5, d);
        chk_bit("gfx1_cs", 1'b0, last_gfx1_cs);
        chk_bit("gfx2_cs", 1'b1, last_gfx2_cs);
        w0 = gfx2_writes;
        bus_write(16'h2100, 8'h77);
        chk_byte("gfx2 vid_we", 8'd1, 8'(gfx2_writes - w0));
        chk_vid_addr("vid_addr", 13'h0100, gfx2_wr_addr);  // 8 KB window offset
        chk_byte("vid_wdata", 8'h77, gfx2_wr_data);
        bus_read(16'h0640, d);
        chk_byte("pal rd_data", 8'h3c, d);
        chk_bit("pal_cs", 1'b1, last_pal_cs);
        r = rand32();
        bus_write(16'h040c, r[31:24]);
        chk_byte("video_bank", r[31:24], video_bank);
        bus_write(16'h0410, 8'h00);
    endtask

    task automatic test_sound();
        logic [31:0] r;
        int          p0;
        r = rand32();
        bus_write(16'h0414, r[31:24]);
        chk_byte("snd_latch", r[31:24], snd_latch);
        p0 = snd_pulses;
        bus_write(16'h0418, ~r[31:24]);      // Strobe only and the latch stays
        repeat (2) @(negedge clk);
        chk_byte("snd_irq pulses", 8'd1, 8'(snd_pulses - p0));
        chk_byte("snd_latch", r[31:24], snd_latch);
    endtask

    task automatic test_irq();
        @(posedge clk);
        dip.pause <= 1'b1;
        @(posedge clk);
        gfx_irqn <= 1'b0;
        @(negedge clk);
        chk_bit("irq_n", 1'b1, irq_n);
        @(negedge clk);
        chk_bit("irq_n", 1'b0, irq_n);       // One cycle after the edge
        @(posedge clk);
        gfx_irqn <= 1'b1;                    // Latch outlives the line
        repeat (4) @(negedge clk);
        chk_bit("irq_n", 1'b0, irq_n);       // Held until acknowledged
        @(posedge clk);
        irq_ack <= 1'b1;
        @(negedge clk);
        chk_bit("irq_n", 1'b0, irq_n);
        @(posedge clk);
        irq_ack <= 1'b0;
        @(negedge clk);
        chk_bit("irq_n", 1'b1, irq_n);       // One cycle after irq_ack
        @(posedge clk);
        dip.pause <= 1'b0;
        @(posedge clk);
        gfx_irqn <= 1'b0;                    // Masked by pause low
        repeat (4) @(negedge clk);
        chk_bit("irq_n", 1'b1, irq_n);
        @(posedge clk);
        gfx_irqn <= 1'b1;
    endtask

/* bench/tb_main_board.sv */
// Testbench for the main CPU board
// Clock, reset, ROM and video models, watchdog and the directed test run
`timescale 1ns/1ns

module tb_main_board;
    import main_pkg::*;

    localparam int          CLK_PERIOD = 8;
    localparam int          N_TESTS    = 7;
    localparam logic [31:0] SEED       = 32'ha71e_075d;

    logic              clk = 1'b0;
    logic              rst;
    logic              req;
    cpu_bus_t          bus;
    logic              ack;
    logic [7:0]        rd_data;
    logic [ROM_AW-1:0] rom_addr;
    logic              rom_cs;
    logic [7:0]        rom_data = 8'h00;
    logic              rom_ok = 1'b0;
    logic [12:0]       vid_addr;
    logic [7:0]        vid_wdata;
    logic              vid_we;
    logic              gfx1_cs;
    logic              gfx2_cs;
    logic              pal_cs;
    logic [7:0]        gfx1_dout;
    logic [7:0]        gfx2_dout;
    logic [7:0]        pal_dout;
    logic [7:0]        video_bank;
    logic              prio;
    logic [7:0]        snd_latch;
    logic              snd_irq;
    logic              gfx_irqn;
    logic              irq_ack;
    logic              irq_n;
    cab_in_t           cab;
    dip_t              dip;

    int                errors = 0;
    int                checks = 0;
    logic [31:0]       seed = SEED;      // Test stimulus stream
    logic [31:0]       rom_seed = SEED;  // ROM delay stream of the ROM model
    logic [2:0]        rom_wait = 3'd0;
    int                snd_pulses = 0;
    int                gfx2_writes = 0;
    logic [12:0]       gfx2_wr_addr;     // Last write seen by gfx2
    logic [7:0]        gfx2_wr_data;
    // Last access as seen while ack was high
    logic [ROM_AW-1:0] last_rom_addr;
    logic [7:0]        last_lat;
    logic              last_gfx1_cs;
    logic              last_gfx2_cs;
    logic              last_pal_cs;

    always #(CLK_PERIOD / 2) clk = ~clk;

    main_board #(.RAM_AW(12)) u_main_board (
        .clk(clk), .rst(rst), .req(req), .bus(bus), .ack(ack), .rd_data(rd_data),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok),
        .vid_addr(vid_addr), .vid_wdata(vid_wdata), .vid_we(vid_we),
        .gfx1_cs(gfx1_cs), .gfx2_cs(gfx2_cs), .pal_cs(pal_cs),
        .gfx1_dout(gfx1_dout), .gfx2_dout(gfx2_dout), .pal_dout(pal_dout),
        .video_bank(video_bank), .prio(prio), .snd_latch(snd_latch), .snd_irq(snd_irq),
        .gfx_irqn(gfx_irqn), .irq_ack(irq_ack), .irq_n(irq_n), .cab(cab), .dip(dip)
    );

    `include "main_checks.svh"

    // Slow ROM port with 0 to 7 idle cycles before rom_ok
    always @(posedge clk) begin
        if (rst) begin
            rom_ok <= 1'b0;
        end else if (rom_ok) begin
            rom_ok <= 1'b0;                     // Single cycle strobe
        end else if (rom_cs) begin
            if (rom_wait == 3'd0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_byte(rom_addr);
                rom_seed = lcg_step(rom_seed);
                rom_wait <= rom_seed[18:16];    // Delay for the next fetch
            end else begin
                rom_wait <= rom_wait - 3'd1;
            end
        end
    end

    // Strobe counters and the last gfx2 write
    always @(negedge clk) begin
        if (snd_irq) snd_pulses++;
        if (vid_we && gfx2_cs) begin
            gfx2_writes++;
            gfx2_wr_addr = vid_addr;
            gfx2_wr_data = vid_wdata;
        end
    end

    initial begin
        rst       = 1'b1;
        req       = 1'b0;
        bus       = '0;
        gfx1_dout = 8'h5a;  // Fixed bytes tell the sources apart
        gfx2_dout = 8'ha5;
        pal_dout  = 8'h3c;
        gfx_irqn  = 1'b1;
        irq_ack   = 1'b0;
        cab       = '1;
        dip       = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        test_reset_values();
        test_rom_reads();
        test_ram();
        test_inputs();
        test_video();
        test_sound();
        test_irq();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // 2000 clock periods per test
    initial begin
        #(N_TESTS * 2000 * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("test failed");
        $finish;
    end

endmodule

/* hdl/addr_decode.sv */
// Main CPU memory map
// One-hot selects from the address plus banked ROM address
`timescale 1ns/1ns

module addr_decode (
    input  logic [15:0]                   addr,
    input  logic                          video_sel, // 0 gfx1, 1 gfx2
    input  logic [3:0]                    bank,
    output main_pkg::mem_sel_t            sel,
    output logic [main_pkg::ROM_AW-1:0]   rom_addr
);

    logic       rom_area;
    logic       ram_area;
    logic       io_area;
    logic       vid_area;
    logic       pal_area;

    // Only A15-A9 reach the first decoder, I/O then looks at A[5:2]
    always_comb begin
        rom_area = addr[15] || addr[15:14] == 2'b01;         // 4000-FFFF
        ram_area = addr[15:12] == 4'h1;                      // 1000-1FFF
        io_area  = addr[15:9] == 7'h02 && !addr[5];          // 0400-041F
        vid_area = addr[15:13] == 3'b001 || addr[15:9] == 7'h00;
        pal_area = addr[15:9] == 7'h03;                      // 0600-07FF
    end

    // Priority order ROM, RAM, I/O, video, palette
    always_comb begin
        sel = '0;
        if (rom_area) begin
            sel.rom = 1'b1;
        end else if (ram_area) begin
            sel.ram = 1'b1;
        end else if (io_area) begin
            case (addr[4:2])
                3'b000, 3'b001: sel.in = 1'b1;    // 0400-0407, eight ports
                3'b011: sel.vbank     = 1'b1;     // 040C
                3'b100: sel.bank      = 1'b1;     // 0410
                3'b101: sel.snd_latch = 1'b1;     // 0414
                3'b110: sel.snd_irq   = 1'b1;     // 0418
                default: sel.none     = 1'b1;     // Coin counters, watchdog
            endcase
        end else if (vid_area) begin
            sel.gfx1 = !video_sel;
            sel.gfx2 = video_sel;
        end else if (pal_area) begin
            sel.pal = 1'b1;
        end else begin
            sel.none = 1'b1;
        end
    end

    // 8000-FFFF fixed in the low 32 KB, 4000-7FFF paged in 8 KB steps
    always_comb begin
        if (addr[15]) begin
            rom_addr = {2'b00, addr[14:0]};
        end else begin
            rom_addr = {bank + 4'd4, addr[12:0]}; // Pages start past the fixed area
        end
    end

endmodule

/* hdl/board_regs.sv */
// Board registers
// ROM bank, video bank, sound latch and the video interrupt latch
`timescale 1ns/1ns

module board_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_stb,
    input  main_pkg::mem_sel_t sel,
    input  logic [7:0]         wdata,
    output logic               video_sel,
    output logic               prio,
    output logic [3:0]         bank,
    output logic [7:0]         video_bank,
    output logic [7:0]         snd_latch,
    output logic               snd_irq,
    input  logic               gfx_irqn,
    input  logic               pause,
    input  logic               irq_ack,
    output logic               irq_n
);
    import main_pkg::*;

    bank_word_u bank_reg;   // Register at 0410
    logic       irq_trig;
    logic       irq_trig_l; // Previous trigger for edge detect

    always_ff @(posedge clk) begin
        if (rst) begin
            bank_reg.raw <= 8'd0;
            video_bank   <= 8'd0;
            snd_latch    <= 8'd0;
            snd_irq      <= 1'b0;
        end else begin
            snd_irq <= wr_stb && sel.snd_irq; // One pulse per write
            if (wr_stb && sel.bank) bank_reg.raw <= wdata;
            if (wr_stb && sel.vbank) video_bank <= wdata;
            if (wr_stb && sel.snd_latch) snd_latch <= wdata;
        end
    end

    assign video_sel = bank_reg.fields.video_sel;
    assign prio      = bank_reg.fields.prio;
    assign bank      = bank_reg.fields.bank;

    // Pause low masks the video interrupt
    assign irq_trig = !gfx_irqn && pause;

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_trig_l <= 1'b0;
            irq_n      <= 1'b1;
        end else begin
            irq_trig_l <= irq_trig;
            if (irq_ack) begin
                irq_n <= 1'b1;                 // Ack wins over a new edge
            end else if (irq_trig && !irq_trig_l) begin
                irq_n <= 1'b0;
            end
        end
    end

endmodule

/* hdl/bus_seq.sv */
// Bus sequencer for the four-phase CPU port
// Latches each request, waits on ROM, picks read data, raises ack
`timescale 1ns/1ns

module bus_seq (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  main_pkg::cpu_bus_t  bus,
    output logic                ack,
    output logic [7:0]          rd_data,
    input  main_pkg::mem_sel_t  sel,      // Decoded from acc_bus
    output logic                rom_cs,
    input  logic [7:0]          rom_data,
    input  logic                rom_ok,
    input  logic [7:0]          ram_q,
    input  logic [7:0]          port_q,
    input  logic [7:0]          gfx1_dout,
    input  logic [7:0]          gfx2_dout,
    input  logic [7:0]          pal_dout,
    output logic                gfx1_cs,
    output logic                gfx2_cs,
    output logic                pal_cs,
    output logic                wr_stb,
    output main_pkg::cpu_bus_t  acc_bus
);

    localparam logic [2:0] IDLE     = 3'd0;
    localparam logic [2:0] ACCESS   = 3'd1;
    localparam logic [2:0] ROM_WAIT = 3'd2;
    localparam logic [2:0] DONE     = 3'd3;
    localparam logic [2:0] RELEASE  = 3'd4;

    logic [2:0] state;
    logic [7:0] rom_q;   // ROM byte caught on rom_ok
    logic       busy;
    logic       rom_rd;  // Only ROM reads wait on the SDRAM side

    assign busy   = state != IDLE;
    assign rom_rd = sel.rom && acc_bus.rnw;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:     if (req) state <= ACCESS;
                ACCESS:   state <= (rom_rd && !rom_ok) ? ROM_WAIT : DONE;
                ROM_WAIT: if (rom_ok) state <= DONE;
                DONE:     state <= RELEASE;           // Write lands here
                RELEASE:  if (!req) state <= IDLE;    // Wait for the master
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) acc_bus <= bus;
        if (rom_cs && rom_ok) rom_q <= rom_data;
    end

    assign rom_cs  = rom_rd && (state == ACCESS || state == ROM_WAIT);
    assign ack     = state == DONE || state == RELEASE;
    assign wr_stb  = state == DONE && !acc_bus.rnw; // Single cycle
    assign gfx1_cs = busy && sel.gfx1;
    assign gfx2_cs = busy && sel.gfx2;
    assign pal_cs  = busy && sel.pal;

    // Sources hold still while ack is high
    always_comb begin
        case (1'b1)
            sel.rom:  rd_data = rom_q;
            sel.ram:  rd_data = ram_q;   // Registered read, ready by DONE
            sel.in:   rd_data = port_q;
            sel.gfx1: rd_data = gfx1_dout;
            sel.gfx2: rd_data = gfx2_dout;
            sel.pal:  rd_data = pal_dout;
            default:  rd_data = 8'hff;   // Write-only or unmapped
        endcase
    end

endmodule

/* hdl/cab_inputs.sv */
// Cabinet input ports
// Buttons, joysticks and DIP banks as eight readable bytes
`timescale 1ns/1ns

module cab_inputs (
    input  logic                clk,
    input  logic [2:0]          port_sel,   // A[2:0]
    input  main_pkg::cab_in_t   cab,
    input  main_pkg::dip_t      dip,
    output logic [7:0]          port_q
);

    // Unused bits read high
    always_ff @(posedge clk) begin
        case (port_sel)
            3'd0: port_q <= {3'b111, cab.start, cab.service, cab.coin};
            3'd1: begin
                port_q <= {2'b11, cab.joy1[5:4], cab.joy1[2], cab.joy1[3],
                           cab.joy1[0], cab.joy1[1]};     // Directions swapped in pairs
            end
            3'd2: begin
                port_q <= {2'b11, cab.joy2[5:4], cab.joy2[2], cab.joy2[3],
                           cab.joy2[0], cab.joy2[1]};
            end
            3'd4: port_q <= dip.dip_a;
            3'd5: port_q <= dip.dip_b;
            3'd6: port_q <= {4'hf, dip.dip_c};
            default: port_q <= 8'hff;  // Ports 3 and 7
        endcase
    end

endmodule

/* hdl/main_board.sv */
// Main CPU board
// Bus sequencer, memory map, board registers, input ports and work RAM
`timescale 1ns/1ns

module main_board #(
    parameter int RAM_AW = 12  // 4 KB work RAM at 1000
) (
    input  logic                          clk,
    input  logic                          rst,
    // CPU bus, four-phase req/ack
    input  logic                          req,
    input  main_pkg::cpu_bus_t            bus,
    output logic                          ack,
    output logic [7:0]                    rd_data,
    // Program ROM
    output logic [main_pkg::ROM_AW-1:0]   rom_addr,
    output logic                          rom_cs,
    input  logic [7:0]                    rom_data,
    input  logic                          rom_ok,
    // Video chips and palette
    output logic [12:0]                   vid_addr,
    output logic [7:0]                    vid_wdata,
    output logic                          vid_we,
    output logic                          gfx1_cs,
    output logic                          gfx2_cs,
    output logic                          pal_cs,
    input  logic [7:0]                    gfx1_dout,
    input  logic [7:0]                    gfx2_dout,
    input  logic [7:0]                    pal_dout,
    output logic [7:0]                    video_bank,
    output logic                          prio,
    // Sound CPU
    output logic [7:0]                    snd_latch,
    output logic                          snd_irq,
    // Interrupt
    input  logic                          gfx_irqn,
    input  logic                          irq_ack,
    output logic                          irq_n,
    // Cabinet
    input  main_pkg::cab_in_t             cab,
    input  main_pkg::dip_t                dip
);
    import main_pkg::*;

    cpu_bus_t   acc_bus;    // Request under way
    mem_sel_t   sel;
    logic       wr_stb;
    logic [7:0] ram_q;
    logic [7:0] port_q;
    logic       video_sel;
    logic [3:0] bank;

    assign vid_addr  = acc_bus.addr[12:0]; // Chips see 8 KB windows
    assign vid_wdata = acc_bus.wdata;
    assign vid_we    = wr_stb;             // Qualified by the chip selects

    bus_seq u_bus_seq (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .bus       (bus),
        .ack       (ack),
        .rd_data   (rd_data),
        .sel       (sel),
        .rom_cs    (rom_cs),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .ram_q     (ram_q),
        .port_q    (port_q),
        .gfx1_dout (gfx1_dout),
        .gfx2_dout (gfx2_dout),
        .pal_dout  (pal_dout),
        .gfx1_cs   (gfx1_cs),
        .gfx2_cs   (gfx2_cs),
        .pal_cs    (pal_cs),
        .wr_stb    (wr_stb),
        .acc_bus   (acc_bus)
    );

    addr_decode u_addr_decode (
        .addr      (acc_bus.addr),
        .video_sel (video_sel),
        .bank      (bank),
        .sel       (sel),
        .rom_addr  (rom_addr)
    );

    board_regs u_board_regs (
        .clk        (clk),
        .rst        (rst),
        .wr_stb     (wr_stb),
        .sel        (sel),
        .wdata      (acc_bus.wdata),
        .video_sel  (video_sel),
        .prio       (prio),
        .bank       (bank),
        .video_bank (video_bank),
        .snd_latch  (snd_latch),
        .snd_irq    (snd_irq),
        .gfx_irqn   (gfx_irqn),
        .pause      (dip.pause),
        .irq_ack    (irq_ack),
        .irq_n      (irq_n)
    );

    cab_inputs u_cab_inputs (
        .clk      (clk),
        .port_sel (acc_bus.addr[2:0]),
        .cab      (cab),
        .dip      (dip),
        .port_q   (port_q)
    );

    work_ram #(
        .RAM_AW (RAM_AW)
    ) u_work_ram (
        .clk   (clk),
        .we    (wr_stb && sel.ram),
        .addr  (acc_bus.addr[RAM_AW-1:0]),
        .wdata (acc_bus.wdata),
        .q     (ram_q)
    );

endmodule

/* hdl/main_pkg.sv */
// Main CPU board shared definitions
// Bus request, memory selects, bank register view and cabinet inputs
package main_pkg;

    localparam int ROM_AW = 17; // 128 KB program ROM space

    // Request from the CPU side, held stable while req is high
    typedef struct packed {
        logic [15:0] addr;
        logic        rnw;   // 1 read, 0 write
        logic [7:0]  wdata;
    } cpu_bus_t;

    // One-hot memory selects
    typedef struct packed {
        logic rom;
        logic ram;
        logic gfx1;      // video chip 1
        logic gfx2;      // video chip 2
        logic pal;
        logic in;        // input ports
        logic vbank;     // video ROM bank
        logic bank;      // ROM bank, chip select, priority
        logic snd_latch;
        logic snd_irq;
        logic none;      // unmapped
    } mem_sel_t;

    typedef struct packed {
        logic       spare;
        logic       video_sel; // Which video chip gets the CPU
        logic       prio;
        logic       bank_en;
        logic [3:0] bank;      // Banked ROM page
    } bank_fields_t;

    // Bank register byte, raw or by field
    typedef union packed {
        logic [7:0]   raw;
        bank_fields_t fields;
    } bank_word_u;

    typedef struct packed {
        logic [1:0] start;
        logic [1:0] coin;
        logic [5:0] joy1;
        logic [5:0] joy2;
        logic       service;
        logic [1:0] spare;  // Pad to 19 bits
    } cab_in_t;

    typedef struct packed {
        logic [7:0] dip_a;
        logic [7:0] dip_b;
        logic [3:0] dip_c;
        logic       pause;  // Low holds off the video interrupt
    } dip_t;

endpackage

/* hdl/work_ram.sv */
// Work RAM for the main CPU
// Single port bytes, read data one cycle after the address
`timescale 1ns/1ns

module work_ram #(
    parameter int RAM_AW = 12
) (
    input  logic              clk,
    input  logic              we,
    input  logic [RAM_AW-1:0] addr,
    input  logic [7:0]        wdata,
    output logic [7:0]        q
);

    logic [7:0] mem [0:(1 << RAM_AW) - 1];

    always_ff @(posedge clk) begin
        if (we) mem[addr] <= wdata;
        q <= mem[addr];  // Old data on a write cycle
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the main board testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_main_board -f tb.f \
    --Mdir obj_dir -o sim_main_board

./obj_dir/sim_main_board > sim.log 2>&1
cat sim.log

# Pass only if the testbench printed its pass line
grep -qx "test passed" sim.log

/* tb.f */
+incdir+bench
hdl/main_pkg.sv
hdl/addr_decode.sv
hdl/bus_seq.sv
hdl/board_regs.sv
hdl/cab_inputs.sv
hdl/work_ram.sv
hdl/main_board.sv
bench/tb_main_board.sv
